/* fsab_pkg.sv */
package fsab_pkg;

	// ####################
	// bus geometry
	// ####################

	localparam int fsab_devices = 3;
	localparam int fsab_dev_w = 2;
	localparam int fsab_subdid_w = 4;
	localparam int fsab_addr_w = 8;
	localparam int fsab_data_w = 64;
	localparam int fsab_mask_w = fsab_data_w / 8;

	// beats per transaction, 1 to 4
	localparam int fsab_len_w = 3;
	localparam int fsab_max_len = 4;

	// ####################
	// buffering and credits
	// ####################

	// room for two full-length writes per device
	localparam int fsab_buf_depth = 2 * fsab_max_len;
	localparam int fsab_buf_ptr_w = $clog2(fsab_buf_depth);
	localparam int fsab_buf_credits = fsab_buf_depth / fsab_max_len;

	localparam int fsab_credit_w = 2;
	// one outstanding transaction at the memory
	localparam logic [fsab_credit_w-1:0] fsab_initial_credits = 1;

	typedef enum logic [1:0] {
		mode_read  = 2'd0,
		mode_write = 2'd1
	} fsab_mode_t;

	typedef struct packed {
		logic                     valid;
		fsab_mode_t               mode;
		logic [fsab_dev_w-1:0]    did;
		logic [fsab_subdid_w-1:0] subdid;
		logic [fsab_addr_w-1:0]   addr;
		logic [fsab_len_w-1:0]    len;
		logic [fsab_data_w-1:0]   data;
		logic [fsab_mask_w-1:0]   mask;
	} fsab_beat_t;

	typedef struct packed {
		logic                     valid;
		logic [fsab_dev_w-1:0]    did;
		logic [fsab_subdid_w-1:0] subdid;
		logic [fsab_data_w-1:0]   data;
	} fsab_rsp_t;

	typedef fsab_beat_t [fsab_devices-1:0] fsab_beat_vec_t;

	// bus beats taken by the transaction whose header is b
	// a read is just its header, a write carries len beats
	function automatic logic [fsab_len_w-1:0] fsab_beats(fsab_beat_t b);
		return (b.mode == mode_write) ? b.len : fsab_len_w'(1);
	endfunction

endpackage

/* fsab_req_fifo.sv */
module fsab_req_fifo (
	input  logic                 clk,
	input  logic                 rst_b,
	input  fsab_pkg::fsab_beat_t req_in,
	input  logic                 start,
	output fsab_pkg::fsab_beat_t beat_out,
	output logic                 pending,
	output logic                 active,
	output logic                 credit
);

	fsab_pkg::fsab_beat_t entries [fsab_pkg::fsab_buf_depth];

	logic [fsab_pkg::fsab_buf_ptr_w-1:0] wr_ptr;
	logic [fsab_pkg::fsab_buf_ptr_w-1:0] rd_ptr;

	// beats still to come in / go out for the transaction in flight
	logic [fsab_pkg::fsab_len_w-1:0] in_left;
	logic [fsab_pkg::fsab_len_w-1:0] out_left;

	// complete transactions sitting in the buffer, not yet started
	logic [fsab_pkg::fsab_credit_w-1:0] txn_count;
	logic                               in_done;

	fsab_pkg::fsab_beat_t head;

	// ####################
	// fill side
	// ####################

	// the last beat of a transaction arrives this cycle
	always_comb begin
		if (!req_in.valid)
			in_done = 1'b0;
		else if (in_left == '0)
			in_done = (fsab_pkg::fsab_beats(req_in) == 1);
		else
			in_done = (in_left == 1);
	end

	always_ff @(posedge clk) begin
		if (req_in.valid)
			entries[wr_ptr] <= req_in;
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			wr_ptr <= '0;
			in_left <= '0;
		end else if (req_in.valid) begin
			wr_ptr <= wr_ptr + 1'b1;
			// a header beat loads the remaining count
			if (in_left == '0)
				in_left <= fsab_pkg::fsab_beats(req_in) - 1'b1;
			else
				in_left <= in_left - 1'b1;
		end
	end

	// start never lands on a cycle that has nothing queued
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			txn_count <= '0;
		end else begin
			case ({in_done, start})
				2'b10: txn_count <= txn_count + 1'b1;
				2'b01: txn_count <= txn_count - 1'b1;
				default: ;
			endcase
		end
	end

	assign pending = (txn_count != '0);

	// ####################
	// drain side
	// ####################

	assign head = entries[rd_ptr];
	// valid is qualified by active in the arbiter
	assign beat_out = head;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			rd_ptr <= '0;
			out_left <= '0;
			active <= 1'b0;
			credit <= 1'b0;
		end else begin
			// one credit back per transaction, right after its last beat
			credit <= active && (out_left == 1);
			if (start) begin
				active <= 1'b1;
				out_left <= fsab_pkg::fsab_beats(head);
			end else if (active) begin
				rd_ptr <= rd_ptr + 1'b1;
				out_left <= out_left - 1'b1;
				if (out_left == 1)
					active <= 1'b0;
			end
		end
	end

endmodule

/* fsab_arbiter.sv */
module fsab_arbiter (
	input  logic                                clk,
	input  logic                                rst_b,
	input  fsab_pkg::fsab_beat_vec_t            req_in,
	input  logic                                mem_credit,
	output logic [fsab_pkg::fsab_devices-1:0]   credits,
	output fsab_pkg::fsab_beat_t                bus_out
);

	// ####################
	// request buffers
	// ####################

	// each buffer flags pending once a whole transaction is stored
	// a start pulse hands it the bus until it drops active again

	fsab_pkg::fsab_beat_vec_t           fifo_beat;
	logic [fsab_pkg::fsab_devices-1:0]  pending;
	logic [fsab_pkg::fsab_devices-1:0]  active;
	logic [fsab_pkg::fsab_devices-1:0]  start;

	for (genvar i = 0; i < fsab_pkg::fsab_devices; i++) begin : g_fifo
		fsab_req_fifo u_fifo (
			.clk      (clk),
			.rst_b    (rst_b),
			.req_in   (req_in[i]),
			.start    (start[i]),
			.beat_out (fifo_beat[i]),
			.pending  (pending[i]),
			.active   (active[i]),
			.credit   (credits[i])
		);
	end

	// ####################
	// target credits
	// ####################

	logic [fsab_pkg::fsab_credit_w-1:0] target_credits;
	logic                               credit_avail;

	assign credit_avail = (target_credits != '0);

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			target_credits <= fsab_pkg::fsab_initial_credits;
		end else begin
			case ({mem_credit, |start})
				2'b10: target_credits <= target_credits + 1'b1;
				2'b01: target_credits <= target_credits - 1'b1;
				default: ;
			endcase
		end
	end

	// ####################
	// device selection
	// ####################

	logic [fsab_pkg::fsab_dev_w-1:0] cur_dev;
	logic [fsab_pkg::fsab_dev_w-1:0] next_dev;
	logic                            new_sel;

	// highest-numbered pending buffer wins, no fairness
	always_comb begin
		next_dev = '0;
		for (int i = 0; i < fsab_pkg::fsab_devices; i++) begin
			if (pending[i])
				next_dev = i[fsab_pkg::fsab_dev_w-1:0];
		end
	end

	// free to pick again once the owner has let go
	assign new_sel = !active[cur_dev];

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b)
			cur_dev <= '0;
		else if (new_sel)
			cur_dev <= next_dev;
	end

	always_comb begin
		start = '0;
		start[next_dev] = new_sel && pending[next_dev] && credit_avail;
	end

	// ####################
	// output routing
	// ####################

	// stale entries still carry valid, so gate with active
	always_comb begin
		bus_out = fifo_beat[cur_dev];
		bus_out.valid = fifo_beat[cur_dev].valid & active[cur_dev];
	end

endmodule

/* fsab_mem.sv */
module fsab_mem (
	input  logic                 clk,
	input  logic                 rst_b,
	input  fsab_pkg::fsab_beat_t bus_in,
	output fsab_pkg::fsab_rsp_t  rsp_out,
	output logic                 mem_credit
);

	logic [fsab_pkg::fsab_data_w-1:0] storage [2**fsab_pkg::fsab_addr_w];

	// ####################
	// write path
	// ####################

	// write beats still expected after the header
	logic [fsab_pkg::fsab_len_w-1:0]  wr_left;
	logic [fsab_pkg::fsab_addr_w-1:0] wr_addr;
	logic [fsab_pkg::fsab_addr_w-1:0] wr_sel;

	logic hdr_write;
	logic hdr_read;
	logic wr_en;
	logic wr_last;

	// a valid beat with no burst open is a header
	assign hdr_write = bus_in.valid && (wr_left == '0) && (bus_in.mode == fsab_pkg::mode_write);
	assign hdr_read = bus_in.valid && (wr_left == '0) && (bus_in.mode == fsab_pkg::mode_read);

	assign wr_en = hdr_write || (bus_in.valid && (wr_left != '0));
	assign wr_last = (hdr_write && (bus_in.len == 1)) || (bus_in.valid && (wr_left == 1));

	// header uses its own address, later beats follow on
	assign wr_sel = (wr_left == '0) ? bus_in.addr : wr_addr;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int b = 0; b < fsab_pkg::fsab_mask_w; b++) begin
				if (bus_in.mask[b])
					storage[wr_sel][b*8 +: 8] <= bus_in.data[b*8 +: 8];
			end
		end
	end

	// ####################
	// read path
	// ####################

	logic [fsab_pkg::fsab_len_w-1:0]    rd_left;
	logic [fsab_pkg::fsab_addr_w-1:0]   rd_addr;
	logic [fsab_pkg::fsab_dev_w-1:0]    rd_did;
	logic [fsab_pkg::fsab_subdid_w-1:0] rd_subdid;
	logic                               rd_last;

	assign rd_last = (rd_left == 1);

	// first beat shows up the cycle after the header
	always_comb begin
		rsp_out.valid = (rd_left != '0);
		rsp_out.did = rd_did;
		rsp_out.subdid = rd_subdid;
		rsp_out.data = storage[rd_addr];
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			wr_addr <= wr_sel + 1'b1;
		if (hdr_read) begin
			rd_addr <= bus_in.addr;
			rd_did <= bus_in.did;
			rd_subdid <= bus_in.subdid;
		end else if (rd_left != '0) begin
			rd_addr <= rd_addr + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			wr_left <= '0;
			rd_left <= '0;
			mem_credit <= 1'b0;
		end else begin
			// credit back once the transaction is fully done
			mem_credit <= wr_last || rd_last;
			if (hdr_write)
				wr_left <= bus_in.len - 1'b1;
			else if (bus_in.valid && (wr_left != '0))
				wr_left <= wr_left - 1'b1;
			if (hdr_read)
				rd_left <= bus_in.len;
			else if (rd_left != '0)
				rd_left <= rd_left - 1'b1;
		end
	end

endmodule

/* fsab_arb.sv */
module fsab_arb (
	input  logic                              clk,
	input  logic                              rst_b,
	input  fsab_pkg::fsab_beat_vec_t          req_in,
	output logic [fsab_pkg::fsab_devices-1:0] credits,
	output fsab_pkg::fsab_rsp_t               rsp_out
);

	// shared bus from arbiter to memory
	fsab_pkg::fsab_beat_t bus;
	// target credit back to the arbiter
	logic                 mem_credit;

	fsab_arbiter u_arbiter (
		.clk        (clk),
		.rst_b      (rst_b),
		.req_in     (req_in),
		.mem_credit (mem_credit),
		.credits    (credits),
		.bus_out    (bus)
	);

	fsab_mem u_mem (
		.clk        (clk),
		.rst_b      (rst_b),
		.bus_in     (bus),
		.rsp_out    (rsp_out),
		.mem_credit (mem_credit)
	);

endmodule

/* fsab_assert.sv */
module fsab_assert (
	input logic                               clk,
	input logic                               rst_b,
	input logic [fsab_pkg::fsab_devices-1:0]  start,
	input logic                               mem_credit,
	input logic [fsab_pkg::fsab_devices-1:0]  active,
	input logic                               bus_valid
);

	// transactions started and not yet credited back by the memory
	logic [fsab_pkg::fsab_credit_w-1:0] in_flight;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b)
			in_flight <= '0;
		else if (|start && !mem_credit)
			in_flight <= in_flight + 1'b1;
		else if (mem_credit && !(|start))
			in_flight <= in_flight - 1'b1;
	end

	// at most one buffer starting or owning the bus per cycle
	start_onehot: assert property (@(posedge clk) disable iff (!rst_b)
		$onehot0(start | active))
		else $error("more than one buffer started or active in a cycle");

	// a start spends a target credit
	start_credit: assert property (@(posedge clk) disable iff (!rst_b)
		|start |-> in_flight < fsab_pkg::fsab_initial_credits)
		else $error("start issued with no target credit");

	// no beat on the bus from an idle buffer
	// each beat follows a start or the beat before it
	valid_after_start: assert property (@(posedge clk) disable iff (!rst_b)
		bus_valid |-> $past(|start) || $past(bus_valid))
		else $error("bus beat valid without a started transaction");

endmodule

bind fsab_arbiter fsab_assert u_assert (
	.clk        (clk),
	.rst_b      (rst_b),
	.start      (start),
	.mem_credit (mem_credit),
	.active     (active),
	.bus_valid  (bus_out.valid)
);

/* fsab_tb.sv */
module fsab_tb;

	localparam int n_rows = 16;
	localparam int n_groups = 5;
	localparam int reset_cycles = 10;

	// one transaction per row, order gives its place among the group's responses
	typedef struct packed {
		logic [3:0]                       group;
		logic [fsab_pkg::fsab_dev_w-1:0]  dev;
		fsab_pkg::fsab_mode_t             mode;
		logic [fsab_pkg::fsab_addr_w-1:0] addr;
		logic [fsab_pkg::fsab_len_w-1:0]  len;
		logic [fsab_pkg::fsab_mask_w-1:0] mask;
		logic [3:0]                       order;
	} row_t;

	row_t rows [n_rows] = '{
		// group, device, mode, address, beats, byte mask, response order
		'{4'd0, 2'd0, fsab_pkg::mode_write, 8'h10, 3'd1, 8'hff, 4'd0},
		'{4'd0, 2'd0, fsab_pkg::mode_write, 8'h40, 3'd4, 8'hff, 4'd0},
		'{4'd0, 2'd1, fsab_pkg::mode_write, 8'h20, 3'd2, 8'hff, 4'd0},
		'{4'd0, 2'd2, fsab_pkg::mode_write, 8'h30, 3'd3, 8'hff, 4'd0},
		'{4'd1, 2'd0, fsab_pkg::mode_read, 8'h10, 3'd1, 8'h00, 4'd2},
		'{4'd1, 2'd0, fsab_pkg::mode_read, 8'h40, 3'd4, 8'h00, 4'd3},
		'{4'd1, 2'd1, fsab_pkg::mode_read, 8'h20, 3'd2, 8'h00, 4'd1},
		'{4'd1, 2'd2, fsab_pkg::mode_read, 8'h30, 3'd3, 8'h00, 4'd0},
		'{4'd2, 2'd0, fsab_pkg::mode_write, 8'h30, 3'd3, 8'hf0, 4'd0},
		'{4'd2, 2'd1, fsab_pkg::mode_write, 8'h20, 3'd2, 8'h0f, 4'd0},
		'{4'd2, 2'd2, fsab_pkg::mode_write, 8'h41, 3'd1, 8'ha5, 4'd0},
		'{4'd3, 2'd0, fsab_pkg::mode_read, 8'h30, 3'd3, 8'h00, 4'd2},
		'{4'd3, 2'd1, fsab_pkg::mode_read, 8'h40, 3'd4, 8'h00, 4'd1},
		'{4'd3, 2'd2, fsab_pkg::mode_read, 8'h20, 3'd2, 8'h00, 4'd0},
		'{4'd4, 2'd1, fsab_pkg::mode_read, 8'h43, 3'd1, 8'h00, 4'd0},
		'{4'd4, 2'd1, fsab_pkg::mode_read, 8'h10, 3'd1, 8'h00, 4'd1}
	};
	string names [n_groups] = '{"full writes", "reads from all devices", "partial writes",
		"partial read back", "back to back reads"};

	logic                              clk = 1'b0;
	logic                              rst_b;
	fsab_pkg::fsab_beat_vec_t          req_in;
	logic [fsab_pkg::fsab_devices-1:0] credits;
	fsab_pkg::fsab_rsp_t               rsp_out;

	logic [fsab_pkg::fsab_data_w-1:0]   ref_mem [2**fsab_pkg::fsab_addr_w];
	logic [fsab_pkg::fsab_data_w-1:0]   wdata [n_rows][fsab_pkg::fsab_max_len];
	logic [fsab_pkg::fsab_subdid_w-1:0] subdid [n_rows];
	fsab_pkg::fsab_rsp_t                exp_q [$];
	int sent [fsab_pkg::fsab_devices];
	int returned [fsab_pkg::fsab_devices];
	int errors = 0;
	int failed_tests = 0;
	int devs_done;
	string test_name = "idle after reset";

	fsab_arb dut0 (
		.clk     (clk),
		.rst_b   (rst_b),
		.req_in  (req_in),
		.credits (credits),
		.rsp_out (rsp_out)
	);

	always #4 clk = ~clk;

	task automatic check_rsp(input string name, input fsab_pkg::fsab_rsp_t exp,
			input fsab_pkg::fsab_rsp_t act);
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected did/subdid/data %0d/%h/%h actual %0d/%h/%h",
				name, exp.did, exp.subdid, exp.data, act.did, act.subdid, act.data);
		end
	endtask

	task automatic check_credits(input string name, input logic [fsab_pkg::fsab_devices-1:0] exp,
			input logic [fsab_pkg::fsab_devices-1:0] act);
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic report_test(input string name, input int first_error);
		if (errors == first_error) begin
			$display("test %s: ok", name);
		end else begin
			failed_tests++;
			$display("test %s: %0d failed checks", name, errors - first_error);
		end
	endtask

	// ####################
	// device models
	// ####################

	// count credit pulses and check every response beat
	always @(negedge clk) begin
		if (rst_b) begin
			for (int d = 0; d < fsab_pkg::fsab_devices; d++)
				if (credits[d])
					returned[d]++;
			if (rsp_out.valid && exp_q.size() == 0) begin
				errors++;
				$display("%s: response for device %0d with no read outstanding", test_name, rsp_out.did);
			end else if (rsp_out.valid) begin
				check_rsp(test_name, exp_q.pop_front(), rsp_out);
			end
		end
	end

	task automatic send_txn(input int r);
		fsab_pkg::fsab_beat_t beat;
		int d;
		int n;
		d = int'(rows[r].dev);
		n = (rows[r].mode == fsab_pkg::mode_write) ? int'(rows[r].len) : 1;
		// hold off while all of this device's credits are out
		while (sent[d] - returned[d] >= fsab_pkg::fsab_buf_credits) begin
			@(posedge clk);
			#1;
			req_in[d] = '0;
		end
		sent[d]++;
		for (int k = 0; k < n; k++) begin
			beat = '{1'b1, rows[r].mode, rows[r].dev, subdid[r],
				rows[r].addr + fsab_pkg::fsab_addr_w'(k), rows[r].len, wdata[r][k], rows[r].mask};
			@(posedge clk);
			#1;
			req_in[d] = beat;
		end
	endtask

	task automatic drive_device(input int d, input int g);
		for (int r = 0; r < n_rows; r++)
			if (rows[r].group == g && rows[r].dev == d)
				send_txn(r);
		@(posedge clk);
		#1;
		req_in[d] = '0;
		devs_done++;
	endtask

	// new random data, reference writes, then expected responses in table order
	task automatic prepare_group(input int g);
		logic [fsab_pkg::fsab_addr_w-1:0] a;
		for (int r = 0; r < n_rows; r++) begin
			if (rows[r].group == g) begin
				subdid[r] = fsab_pkg::fsab_subdid_w'($urandom);
				for (int k = 0; k < fsab_pkg::fsab_max_len; k++)
					wdata[r][k] = {$urandom, $urandom};
				for (int k = 0; k < rows[r].len && rows[r].mode == fsab_pkg::mode_write; k++) begin
					a = rows[r].addr + fsab_pkg::fsab_addr_w'(k);
					for (int b = 0; b < fsab_pkg::fsab_mask_w; b++)
						if (rows[r].mask[b])
							ref_mem[a][b*8 +: 8] = wdata[r][k][b*8 +: 8];
				end
			end
		end
		for (int o = 0; o < n_rows; o++)
			for (int r = 0; r < n_rows; r++)
				if (rows[r].group == g && rows[r].mode == fsab_pkg::mode_read && rows[r].order == o)
					for (int k = 0; k < rows[r].len; k++)
						exp_q.push_back('{1'b1, rows[r].dev, subdid[r],
							ref_mem[rows[r].addr + fsab_pkg::fsab_addr_w'(k)]});
	endtask

	function automatic bit all_returned();
		for (int d = 0; d < fsab_pkg::fsab_devices; d++)
			if (returned[d] < sent[d])
				return 1'b0;
		return 1'b1;
	endfunction

	// ####################
	// test sequence
	// ####################

	initial begin
		int first_error;
		logic [fsab_pkg::fsab_devices-1:0] balanced;
		void'($urandom(34));
		rst_b = 1'b0;
		req_in = '0;
		for (int d = 0; d < fsab_pkg::fsab_devices; d++) begin
			sent[d] = 0;
			returned[d] = 0;
		end
		repeat (reset_cycles) @(posedge clk);
		#1;
		rst_b = 1'b1;
		// nothing requested yet
		repeat (6) begin
			@(negedge clk);
			check_credits(test_name, '0, credits);
			if (rsp_out.valid !== 1'b0) begin
				errors++;
				$display("%s: response valid before any request", test_name);
			end
		end
		report_test(test_name, 0);
		for (int g = 0; g < n_groups; g++) begin
			test_name = names[g];
			first_error = errors;
			prepare_group(g);
			devs_done = 0;
			for (int d = 0; d < fsab_pkg::fsab_devices; d++) begin
				fork
					automatic int dd = d;
					drive_device(dd, g);
				join_none
			end
			while (devs_done < fsab_pkg::fsab_devices || exp_q.size() != 0 || !all_returned())
				@(posedge clk);
			// leave room for any stray credit pulse
			repeat (8) @(posedge clk);
			for (int d = 0; d < fsab_pkg::fsab_devices; d++)
				balanced[d] = (returned[d] == sent[d]);
			check_credits({test_name, " credit return"}, '1, balanced);
			report_test(test_name, first_error);
		end
		$display("%0d tests, %0d failed, %0d failed checks", n_groups + 1, failed_tests, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// 40 cycles per table row on top of reset
	initial begin
		repeat (reset_cycles + 40 * n_rows) @(posedge clk);
		$display("timeout: the run did not finish in time, stuck in %s", test_name);
		$display("Something failed");
		$finish;
	end

endmodule

/* fsab_arb.f */
fsab_pkg.sv
fsab_req_fifo.sv
fsab_arbiter.sv
fsab_mem.sv
fsab_arb.sv
fsab_assert.sv
fsab_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the fsab_arb testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f fsab_arb.f --top-module fsab_tb -o fsab_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

out=$(./obj_dir/fsab_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q '^Everything OK$'; then
	exit 0
fi
exit 1
